//--- include/phy_defs.svh
`ifndef PHY_DEFS_SVH
`define PHY_DEFS_SVH

// Link geometry
`define PHY_LANES  5
`define PHY_SYM_W  10
`define PHY_BYTE_W 8

// Symbols are written abcdei_fghj, bit a in the MSB

// One-symbol commas, RD- forms
`define START_COMMA 10'b001111_1001 // K28.1
`define END_COMMA   10'b001111_0101 // K28.2
`define ACK_COMMA   10'b001111_0011 // K28.3

// Two-symbol commas, matched on lane 1
`define RESEND_PACKET0_COMMA 10'b001111_0010 // K28.4
`define RESEND_PACKET1_COMMA 10'b001111_1010 // K28.5
`define RESEND_PACKET2_COMMA 10'b001111_0110 // K28.6
`define RESEND_PACKET3_COMMA 10'b111010_1000 // K23.7
`define NACK_COMMA           10'b110110_1000 // K27.7

`endif

//--- verilog/phy_rx_pkg.sv
`include "phy_defs.svh"

package phy_rx_pkg;

    // Lane 0 sits in the low ten bits
    typedef logic [`PHY_LANES-1:0][`PHY_SYM_W-1:0] enc_word_t;

    // Lane bytes 0..3 form the payload, lane 4 is {vc, id, req}
    typedef struct packed {
        logic        vc;
        logic [1:0]  id;
        logic [4:0]  req;
        logic [31:0] payload;
    } flit_t;

    typedef enum logic [1:0] {
        SELECT_COMMA_1_FLIT,
        SELECT_COMMA_2_FLIT,
        SELECT_COMMA_DATA
    } comma_len_t;

    typedef enum logic [3:0] {
        START_PACKET_SEL,
        END_PACKET_SEL,
        ACK_SEL,
        RESEND_PACKET0_SEL,
        RESEND_PACKET1_SEL,
        RESEND_PACKET2_SEL,
        RESEND_PACKET3_SEL,
        NACK_SEL,
        DATA_SEL
    } comma_sel_t;

    typedef enum logic [3:0] {
        FMT_LONG_READ   = 4'd0,
        FMT_SHORT_READ  = 4'd1,
        FMT_LONG_WRITE  = 4'd2,
        FMT_SHORT_WRITE = 4'd3,
        FMT_MEM_RESP    = 4'd4,
        FMT_MSG         = 4'd5,
        FMT_SWITCH_CFG  = 4'd6
    } fmt_t;

    // Header views of the first data flit payload
    typedef struct packed {
        fmt_t        fmt;
        logic [3:0]  dest;
        logic [16:0] addr;
        logic [6:0]  length;
    } long_hdr_t;

    typedef struct packed {
        fmt_t        fmt;
        logic [3:0]  dest;
        logic [16:0] rsvd;
        logic [6:0]  length;
    } resp_hdr_t;

    typedef struct packed {
        fmt_t        fmt;
        logic [3:0]  dest;
        logic [7:0]  msg_code;
        logic [8:0]  rsvd;
        logic [6:0]  length;
    } msg_hdr_t;

    typedef struct packed {
        fmt_t        fmt;
        logic [3:0]  dest;
        logic [19:0] addr;
        logic [3:0]  length;  // Words, zero means 16
    } short_hdr_t;

    typedef struct packed {
        enc_word_t  word;
        comma_len_t sel;
        logic       valid;
        logic       err_in;
        logic       rd_err;
    } rx_stage_t;

endpackage

//--- verilog/rx_lane_capture.sv
`timescale 1ns/10ps
`include "phy_defs.svh"

module rx_lane_capture import phy_rx_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  enc_word_t  enc_flit,
    input  logic       done,
    input  logic       err,
    input  comma_len_t comma_length_sel,
    output rx_stage_t  stage
);
    logic [`PHY_LANES-1:0] rd_q;      // 0 = negative, 1 = positive
    logic [`PHY_LANES-1:0] rd_d;
    logic [`PHY_LANES-1:0] lane_err;
    logic [3:0]            ones [`PHY_LANES];

    // Whole-symbol disparity check per lane
    always_comb begin
        rd_d     = rd_q;
        lane_err = '0;
        for (int i = 0; i < `PHY_LANES; i++) begin
            ones[i] = 4'($countones(enc_flit[i]));
            case (ones[i])
                4'd5: begin
                end
                4'd6: begin
                    if (rd_q[i])
                        lane_err[i] = 1'b1;   // Second positive symbol in a row
                    else
                        rd_d[i] = 1'b1;
                end
                4'd4: begin
                    if (!rd_q[i])
                        lane_err[i] = 1'b1;
                    else
                        rd_d[i] = 1'b0;
                end
                default: lane_err[i] = 1'b1; // Not a legal 8b/10b weight
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            stage <= '0;
            rd_q  <= '0;
        end else begin
            stage.word   <= enc_flit;
            stage.sel    <= comma_length_sel;
            stage.valid  <= done;
            stage.err_in <= err;
            stage.rd_err <= done && (|lane_err);
            if (done)
                rd_q <= rd_d;
        end
    end

    // A valid word only follows a clock spent out of reset
    assert property (@(posedge CLK) $rose(stage.valid) |-> nRST && $past(nRST));

endmodule

//--- verilog/dec_8b10b.sv
`timescale 1ns/10ps
`include "phy_defs.svh"

module dec_8b10b (
    input  logic [`PHY_SYM_W-1:0]  data_in,
    output logic [`PHY_BYTE_W-1:0] data_out,
    output logic                   err
);
    logic [5:0] sb6;
    logic [3:0] sb4;
    logic [4:0] edcba;
    logic [2:0] hgf;
    logic       err6;
    logic       err4;

    assign sb6 = data_in[9:4];

    // K28 in its RD+ form carries an inverted fghj block
    assign sb4 = (sb6 == 6'b110000) ? ~data_in[3:0] : data_in[3:0];

    // 6b/5b, both disparity columns
    always_comb begin
        err6  = 1'b0;
        edcba = '0;
        case (sb6)
            6'b100111, 6'b011000: edcba = 5'd0;
            6'b011101, 6'b100010: edcba = 5'd1;
            6'b101101, 6'b010010: edcba = 5'd2;
            6'b110001:            edcba = 5'd3;
            6'b110101, 6'b001010: edcba = 5'd4;
            6'b101001:            edcba = 5'd5;
            6'b011001:            edcba = 5'd6;
            6'b111000, 6'b000111: edcba = 5'd7;
            6'b111001, 6'b000110: edcba = 5'd8;
            6'b100101:            edcba = 5'd9;
            6'b010101:            edcba = 5'd10;
            6'b110100:            edcba = 5'd11;
            6'b001101:            edcba = 5'd12;
            6'b101100:            edcba = 5'd13;
            6'b011100:            edcba = 5'd14;
            6'b010111, 6'b101000: edcba = 5'd15;
            6'b011011, 6'b100100: edcba = 5'd16;
            6'b100011:            edcba = 5'd17;
            6'b010011:            edcba = 5'd18;
            6'b110010:            edcba = 5'd19;
            6'b001011:            edcba = 5'd20;
            6'b101010:            edcba = 5'd21;
            6'b011010:            edcba = 5'd22;
            6'b111010, 6'b000101: edcba = 5'd23; // Also K23
            6'b110011, 6'b001100: edcba = 5'd24;
            6'b100110:            edcba = 5'd25;
            6'b010110:            edcba = 5'd26;
            6'b110110, 6'b001001: edcba = 5'd27; // Also K27
            6'b001110:            edcba = 5'd28;
            6'b101110, 6'b010001: edcba = 5'd29;
            6'b011110, 6'b100001: edcba = 5'd30;
            6'b101011, 6'b010100: edcba = 5'd31;
            6'b001111, 6'b110000: edcba = 5'd28; // K28
            default:              err6  = 1'b1;
        endcase
    end

    // 4b/3b, primary and alternate x.7 included
    always_comb begin
        err4 = 1'b0;
        hgf  = '0;
        case (sb4)
            4'b1011, 4'b0100: hgf = 3'd0;
            4'b1001:          hgf = 3'd1;
            4'b0101:          hgf = 3'd2;
            4'b1100, 4'b0011: hgf = 3'd3;
            4'b1101, 4'b0010: hgf = 3'd4;
            4'b1010:          hgf = 3'd5;
            4'b0110:          hgf = 3'd6;
            4'b1110, 4'b0001: hgf = 3'd7;
            4'b0111, 4'b1000: hgf = 3'd7;
            default:          err4 = 1'b1;
        endcase
    end

    assign data_out = {hgf, edcba};
    assign err      = err6 | err4;

endmodule

//--- verilog/rx_flit_framer.sv
`timescale 1ns/10ps
`include "phy_defs.svh"

module rx_flit_framer import phy_rx_pkg::*; (
    input  logic                  CLK,
    input  logic                  nRST,
    input  rx_stage_t             stage,
    input  flit_t                 dec_flit,
    input  logic [`PHY_LANES-1:0] dec_err,
    output flit_t                 flit,
    output comma_sel_t            comma_sel,
    output logic [7:0]            curr_packet_size,
    output logic                  err_out,
    output logic                  done_out
);
    typedef enum logic [1:0] {
        LOOK_FOR_START,
        LOOK_FOR_DATA,
        LOOK_FOR_END
    } frame_state_t;

    frame_state_t state, n_state;
    flit_t        n_flit;
    comma_sel_t   n_comma_sel;
    logic [7:0]   n_size;
    long_hdr_t    long_hdr;
    resp_hdr_t    resp_hdr;
    msg_hdr_t     msg_hdr;
    short_hdr_t   short_hdr;
    logic [7:0]   long_len;
    logic [7:0]   resp_len;
    logic [7:0]   msg_len;
    logic [7:0]   short_len;

    assign long_hdr  = dec_flit.payload;
    assign resp_hdr  = dec_flit.payload;
    assign msg_hdr   = dec_flit.payload;
    assign short_hdr = dec_flit.payload;

    // Zero length encodes the maximum
    assign long_len  = (long_hdr.length == '0) ? 8'd128 : {1'b0, long_hdr.length};
    assign resp_len  = (resp_hdr.length == '0) ? 8'd128 : {1'b0, resp_hdr.length};
    assign msg_len   = (msg_hdr.length == '0) ? 8'd128 : {1'b0, msg_hdr.length};
    assign short_len = (short_hdr.length == '0) ? 8'd16 : {4'b0, short_hdr.length};

    always_comb begin
        n_flit      = '0;
        n_comma_sel = START_PACKET_SEL;
        n_size      = curr_packet_size;
        n_state     = state;
        case (stage.sel)
            SELECT_COMMA_1_FLIT: begin
                n_size = '0;
                case (stage.word[0])
                    `START_COMMA: begin
                        n_comma_sel = START_PACKET_SEL;
                        n_state     = LOOK_FOR_DATA;
                    end
                    `END_COMMA: begin
                        n_comma_sel = END_PACKET_SEL;
                        n_state     = LOOK_FOR_START;
                    end
                    `ACK_COMMA: n_comma_sel = ACK_SEL;
                    default: begin
                    end
                endcase
            end
            SELECT_COMMA_2_FLIT: begin
                n_size     = '0;
                n_flit.vc  = dec_flit.payload[7];   // Lane 0 byte carries the retry fields
                n_flit.id  = dec_flit.payload[6:5];
                n_flit.req = dec_flit.payload[4:0];
                case (stage.word[1])
                    `RESEND_PACKET0_COMMA: n_comma_sel = RESEND_PACKET0_SEL;
                    `RESEND_PACKET1_COMMA: n_comma_sel = RESEND_PACKET1_SEL;
                    `RESEND_PACKET2_COMMA: n_comma_sel = RESEND_PACKET2_SEL;
                    `RESEND_PACKET3_COMMA: n_comma_sel = RESEND_PACKET3_SEL;
                    `NACK_COMMA:           n_comma_sel = NACK_SEL;
                    default: begin
                    end
                endcase
            end
            SELECT_COMMA_DATA: begin
                n_flit      = dec_flit;
                n_comma_sel = DATA_SEL;
                if (state == LOOK_FOR_DATA) begin
                    // First flit after start is the header
                    case (long_hdr.fmt)
                        FMT_LONG_READ:   n_size = 8'd3;
                        FMT_SHORT_READ:  n_size = 8'd2;
                        FMT_LONG_WRITE:  n_size = 8'd3 + long_len;
                        FMT_SHORT_WRITE: n_size = 8'd2 + short_len;
                        FMT_MEM_RESP:    n_size = 8'd2 + resp_len;
                        FMT_MSG:         n_size = 8'd2 + msg_len;
                        FMT_SWITCH_CFG:  n_size = 8'd255;
                        default: begin
                        end
                    endcase
                    n_state = LOOK_FOR_END;
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            flit             <= '0;
            comma_sel        <= START_PACKET_SEL;
            curr_packet_size <= '0;
            err_out          <= 1'b0;
            done_out         <= 1'b0;
            state            <= LOOK_FOR_START;
        end else if (stage.valid) begin
            flit             <= n_flit;
            comma_sel        <= n_comma_sel;
            curr_packet_size <= n_size;
            err_out          <= stage.err_in | stage.rd_err | (|dec_err);
            done_out         <= 1'b1;
            state            <= n_state;
        end else begin
            err_out  <= stage.err_in;  // Input error level still passes through
            done_out <= 1'b0;
        end
    end

    // Selection only moves on a word that capture marked valid
    assert property (@(posedge CLK) disable iff (!nRST)
        $changed(comma_sel) |-> $past(stage.valid));

endmodule

//--- verilog/phy_rx_top.sv
`timescale 1ns/10ps
`include "phy_defs.svh"

module phy_rx_top import phy_rx_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  enc_word_t  enc_flit,
    input  logic       done,
    input  logic       err,
    input  comma_len_t comma_length_sel,
    output flit_t      flit,
    output comma_sel_t comma_sel,
    output logic [7:0] curr_packet_size,
    output logic       err_out,
    output logic       done_out
);
    rx_stage_t             stage;
    flit_t                 dec_flit;
    logic [`PHY_LANES-1:0] dec_err;

    rx_lane_capture i_capture (
        .CLK              (CLK),
        .nRST             (nRST),
        .enc_flit         (enc_flit),
        .done             (done),
        .err              (err),
        .comma_length_sel (comma_length_sel),
        .stage            (stage)
    );

    // One decoder per lane, byte i of the flit from symbol i
    for (genvar i = 0; i < `PHY_LANES; i++) begin : g_lane_dec
        dec_8b10b i_dec (
            .data_in  (stage.word[i]),
            .data_out (dec_flit[i*`PHY_BYTE_W +: `PHY_BYTE_W]),
            .err      (dec_err[i])
        );
    end

    rx_flit_framer i_framer (
        .CLK              (CLK),
        .nRST             (nRST),
        .stage            (stage),
        .dec_flit         (dec_flit),
        .dec_err          (dec_err),
        .flit             (flit),
        .comma_sel        (comma_sel),
        .curr_packet_size (curr_packet_size),
        .err_out          (err_out),
        .done_out         (done_out)
    );

endmodule

//--- tests/tb_phy_rx.sv
`timescale 1ns/10ps
`include "phy_defs.svh"

module tb_phy_rx import phy_rx_pkg::*; ();
    localparam int NUM_PAT    = 40;
    localparam int NUM_COL    = 13;             // Values per pattern line
    localparam int MAX_CYCLES = 2 * NUM_PAT + 50;
    localparam logic [31:0] LFSR_SEED = 32'h3ef5_d315;

    logic       CLK;
    logic       nRST;
    enc_word_t  enc_flit;
    logic       done;
    logic       err;
    comma_len_t comma_length_sel;
    flit_t      flit;
    comma_sel_t comma_sel;
    logic [7:0] curr_packet_size;
    logic       err_out;
    logic       done_out;

    logic [63:0] pat_mem [NUM_PAT*NUM_COL];
    int          cycles;
    int          missing;
    logic [31:0] lfsr_state;

    phy_rx_top i_phy_rx_top (
        .CLK              (CLK),
        .nRST             (nRST),
        .enc_flit         (enc_flit),
        .done             (done),
        .err              (err),
        .comma_length_sel (comma_length_sel),
        .flit             (flit),
        .comma_sel        (comma_sel),
        .curr_packet_size (curr_packet_size),
        .err_out          (err_out),
        .done_out         (done_out)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // Hard stop if the pattern loop never gets to the end
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge CLK);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Something failed");
        $fatal(1, "Timeout");
    end

    function automatic string group_name(input logic [63:0] grp);
        case (grp)
            64'd1:   return "one_flit_comma";
            64'd2:   return "two_flit_comma";
            64'd3:   return "header_size";
            64'd4:   return "size_hold";
            64'd5:   return "error_merge";
            64'd6:   return "idle_cycle";
            default: return "unknown";
        endcase
    endfunction

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] cur);
        return {cur[30:0], cur[31] ^ cur[21] ^ cur[1] ^ cur[0]};
    endfunction

    // One LFSR step per bit, newest bit lowest
    task automatic random_bits(input int count, output logic [63:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits       = {bits[62:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
            $display("Something failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // Columns: grp sel err done lane4..lane0 then the expected values
    task automatic apply_pattern(input int idx);
        int          base;
        logic [63:0] noise;
        base             = idx * NUM_COL;
        comma_length_sel = comma_len_t'(pat_mem[base+1][1:0]);
        err              = pat_mem[base+2][0];
        done             = pat_mem[base+3][0];
        for (int i = 0; i < `PHY_LANES; i++)
            enc_flit[i] = pat_mem[base+8-i][`PHY_SYM_W-1:0];
        // Noise word and a class that would move comma_sel if the framer took it
        if (!done) begin
            random_bits(`PHY_LANES * `PHY_SYM_W, noise);
            enc_flit = noise[`PHY_LANES*`PHY_SYM_W-1:0];
            if (pat_mem[base+9] == 64'(DATA_SEL))
                comma_length_sel = SELECT_COMMA_1_FLIT;
            else
                comma_length_sel = SELECT_COMMA_DATA;
        end
    endtask

    task automatic idle_inputs();
        done = 1'b0;
        err  = 1'b0;
    endtask

    task automatic compare_outputs(input int idx);
        int    base;
        string tag;
        base = idx * NUM_COL;
        tag  = $sformatf("%s[%0d]", group_name(pat_mem[base]), idx);
        check_value({tag, ".comma_sel"}, pat_mem[base+9], 64'(comma_sel));
        check_value({tag, ".flit"}, pat_mem[base+10], 64'(flit));
        check_value({tag, ".curr_packet_size"}, pat_mem[base+11], 64'(curr_packet_size));
        check_value({tag, ".err_out"}, pat_mem[base+12], 64'(err_out));
        check_value({tag, ".done_out"}, pat_mem[base+3], 64'(done_out)); // Pulse per valid word
    endtask

    initial begin
        nRST             = 1'b0;
        enc_flit         = '0;
        done             = 1'b0;
        err              = 1'b0;
        comma_length_sel = SELECT_COMMA_1_FLIT;
        missing          = 0;
        lfsr_state       = LFSR_SEED;

        $readmemh("tests/phy_rx_patterns.txt", pat_mem);
        for (int i = 0; i < NUM_PAT * NUM_COL; i++) begin
            if ($isunknown(pat_mem[i]))
                missing++;
        end
        if (missing != 0) begin
            $display("Pattern file is short by %0d values", missing);
            $display("Something failed");
            $fatal(1, "Bad pattern file");
        end

        repeat (16) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        // Results of line n appear two rising edges after it is driven
        for (int n = 0; n < NUM_PAT + 2; n++) begin
            @(negedge CLK);
            if (n >= 2)
                compare_outputs(n - 2);
            if (n < NUM_PAT)
                apply_pattern(n);
            else
                idle_inputs();
        end

        $display("Everything OK");
        $finish;
    end

endmodule

//--- tests/phy_rx_patterns.txt
// grp sel err done  lane4 lane3 lane2 lane1 lane0  exp_sel exp_flit exp_size exp_err
// grp 1 one-flit comma, 2 two-flit comma, 3 header, 4 size hold, 5 errors, 6 idle
1 0 0 1  2AA 2AA 2AA 2AA 0F9  0 0000000000 00 0  // start
3 2 0 1  2AA 274 2AA 2AA 189  8 B500B5B520 03 0  // long read
4 2 0 1  2AA 1B4 2AA 2AA 2AA  8 B510B5B5B5 03 0
1 0 0 1  2AA 2AA 2AA 2AA 0F5  1 0000000000 00 0  // end
4 2 0 1  2AA 31C 2AA 2AA 189  8 B563B5B520 00 0  // data after end
1 0 0 1  2AA 2AA 2AA 2AA 0F3  2 0000000000 00 0  // ack
2 1 0 1  2AA 2AA 2AA 0F2 314  3 0300000000 00 0
2 1 0 1  2AA 2AA 2AA 0FA 235  4 5100000000 00 0
2 1 0 1  2AA 2AA 2AA 3A8 31C  6 6300000000 00 0
2 1 0 1  2AA 2AA 2AA 368 2AA  7 B500000000 00 0  // nack
1 0 0 1  2AA 2AA 2AA 189 0F3  2 0000000000 00 0
2 1 0 1  2AA 2AA 2AA 0F6 154  5 0A00000000 00 0
// Header formats, each after a start comma
1 0 0 1  2AA 2AA 2AA 2AA 0F9  0 0000000000 00 0
3 2 0 1  2AA 1B4 2AA 2AA 189  8 B510B5B520 02 0  // short read
1 0 0 1  2AA 2AA 2AA 2AA 0F9  0 0000000000 00 0
3 2 0 1  2AA 319 2AA 2AA 154  8 B523B5B50A 0D 0  // long write
1 0 0 1  2AA 2AA 2AA 2AA 0F9  0 0000000000 00 0
3 2 0 1  2AA 319 2AA 2AA 274  8 B523B5B500 83 0  // long write, zero length
4 2 0 1  2AA 31C 2AA 2AA 189  8 B563B5B520 83 0
1 0 0 1  2AA 2AA 2AA 2AA 0F5  1 0000000000 00 0
2 1 0 1  2AA 2AA 2AA 0F2 189  3 2000000000 00 0
1 0 0 1  2AA 2AA 2AA 2AA 0F9  0 0000000000 00 0
3 2 0 1  2AA 239 2AA 2AA 154  8 B531B5B50A 0C 0  // short write
1 0 0 1  2AA 2AA 2AA 2AA 0F9  0 0000000000 00 0
3 2 0 1  2AA 239 2AA 2AA 249  8 B531B5B530 12 0  // short write, zero length
1 0 0 1  2AA 2AA 2AA 2AA 0F9  0 0000000000 00 0
3 2 0 1  2AA 315 2AA 2AA 314  8 B543B5B503 05 0  // mem resp
1 0 0 1  2AA 2AA 2AA 2AA 0F9  0 0000000000 00 0
3 2 0 1  2AA 235 2AA 2AA 274  8 B551B5B500 82 0  // msg, zero length
4 2 0 1  2AA 2AA 2AA 2AA 314  8 B5B5B5B503 82 0
1 0 0 1  2AA 2AA 2AA 2AA 0F9  0 0000000000 00 0
3 2 0 1  2AA 31C 2AA 2AA 189  8 B563B5B520 FF 0  // switch cfg
// Error sources, then idle cycles
5 2 0 1  2AA 2AA 3C1 2AA 2AA  8 B5B5E0B5B5 FF 1  // invalid 6b block
5 2 0 1  0FA 2AA 2AA 2AA 2AA  8 BCB5B5B5B5 FF 0
5 2 0 1  0FA 2AA 2AA 2AA 2AA  8 BCB5B5B5B5 FF 1  // lane 4 positive twice
5 2 1 1  2AA 2AA 2AA 2AA 2AA  8 B5B5B5B5B5 FF 1
6 2 0 0  2AA 2AA 2AA 2AA 2AA  8 B5B5B5B5B5 FF 0
6 2 1 0  2AA 2AA 2AA 2AA 2AA  8 B5B5B5B5B5 FF 1
6 2 0 0  2AA 2AA 2AA 2AA 2AA  8 B5B5B5B5B5 FF 0
1 0 0 1  2AA 2AA 2AA 2AA 0F5  1 0000000000 00 0

//--- compile.f
+incdir+include
verilog/phy_rx_pkg.sv
verilog/rx_lane_capture.sv
verilog/dec_8b10b.sv
verilog/rx_flit_framer.sv
verilog/phy_rx_top.sv
tests/tb_phy_rx.sv

//--- Bender.yml
package:
  name: phy_rx

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/phy_rx_pkg.sv
      - verilog/rx_lane_capture.sv
      - verilog/dec_8b10b.sv
      - verilog/rx_flit_framer.sv
      - verilog/phy_rx_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_phy_rx.sv
